//--- sp_engine.f
common/sp_field_pkg.sv
common/sp_ctrl_pkg.sv
arith/mod_mul.sv
arith/inv_unit.sv
arith/prod_unit.sv
sort/sort_net.sv
design/sp_ctrl.sv
design/sp_top.sv
dv/sp_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile the sp_engine testbench with verilator and run it
# the exit status is nonzero when the testbench stops on an error
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module sp_tb \
    -f sp_engine.f -o sp_sim \
    && ./obj_dir/sp_sim \
    || { echo "sp_engine simulation did not pass"; exit 1; }

//--- dv/sp_tb.sv
`timescale 1ns/1ps

module sp_tb;

    localparam int TIMEOUT_CYCLES = 4000;
    localparam int P = 509;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        in_valid;
    logic [8:0]  in_data;
    logic [2:0]  in_mode;
    logic        out_valid;
    logic [8:0]  out_data;

    // expected beats, filled per frame and drained by the checker
    logic [8:0]  exp_q [$];
    int          beat_total = 0;
    string       test_name = "reset_idle";
    logic [15:0] lfsr_q = 16'd19348;

    sp_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_mode   (in_mode),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    always #2 clk = ~clk;

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic report_fail(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "run stopped on first error");
    endtask

    // galois lfsr, taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0])
            return (s >> 1) ^ 16'hB400;
        return s >> 1;
    endfunction

    task automatic draw_bits(input int n, output logic [8:0] val);
        val = '0;
        for (int k = 0; k < n; k++) begin
            val    = {val[7:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    // only field elements 0..508
    task automatic draw_element(output logic [8:0] val);
        do
            draw_bits(9, val);
        while (val >= 9'd509);
    endtask

    function automatic logic [53:0] pack6(input int e0, e1, e2, e3, e4, e5);
        return {9'(e5), 9'(e4), 9'(e3), 9'(e2), 9'(e1), 9'(e0)};
    endfunction

    function automatic logic [53:0] scale_by_four(input logic [53:0] frame);
        logic [53:0] res;
        for (int i = 0; i < 6; i++)
            res[9*i +: 9] = 9'((4 * int'(frame[9*i +: 9])) % P);
        return res;
    endfunction

    // expected frame: inverse, product of others, sort, then four-way sum
    function automatic logic [53:0] sp_ref(input logic [53:0] frame, input logic [2:0] mode);
        int v_in   [6];
        int v_inv  [6];
        int v_prod [6];
        int v_sort [6];
        int acc;
        int tmp;
        logic [53:0] res;
        for (int i = 0; i < 6; i++)
            v_in[i] = int'(frame[9*i +: 9]);
        for (int i = 0; i < 6; i++) begin
            acc = 1;
            for (int e = 0; e < P - 2; e++)
                acc = (acc * v_in[i]) % P;
            v_inv[i] = mode[0] ? acc : v_in[i];
        end
        for (int i = 0; i < 6; i++) begin
            acc = 1;
            for (int j = 0; j < 6; j++)
                if (j != i)
                    acc = (acc * v_inv[j]) % P;
            v_prod[i] = mode[1] ? acc : v_inv[i];
        end
        v_sort = v_prod;
        if (mode[2]) begin
            for (int a = 0; a < 5; a++)
                for (int b = 0; b < 5 - a; b++)
                    if (v_sort[b] > v_sort[b+1]) begin
                        tmp         = v_sort[b];
                        v_sort[b]   = v_sort[b+1];
                        v_sort[b+1] = tmp;
                    end
        end
        for (int i = 0; i < 6; i++)
            res[9*i +: 9] = 9'((v_in[i] + v_inv[i] + v_prod[i] + v_sort[i]) % P);
        return res;
    endfunction

    //////////////////////////////
    // stimulus
    //////////////////////////////

    task automatic send_frame(input logic [53:0] frame, input logic [2:0] mode);
        for (int i = 0; i < 6; i++) begin
            @(posedge clk);
            in_valid <= 1'b1;
            in_data  <= frame[9*i +: 9];
            in_mode  <= mode;
        end
        @(posedge clk);
        in_valid <= 1'b0;
        in_data  <= '0;
    endtask

    task automatic wait_out_level(input logic level);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (out_valid !== level && cycles < TIMEOUT_CYCLES);
        assert (out_valid === level) else
            report_fail($sformatf("timeout in %s: out_valid did not reach %0d in %0d cycles",
                                  test_name, level, TIMEOUT_CYCLES));
    endtask

    task automatic run_frame(input string name, input logic [53:0] frame,
                             input logic [2:0] mode, input logic [53:0] expected);
        int beats_before;
        test_name    = name;
        beats_before = beat_total;
        for (int i = 0; i < 6; i++)
            exp_q.push_back(expected[9*i +: 9]);
        send_frame(frame, mode);
        wait_out_level(1'b1);
        wait_out_level(1'b0);
        assert (beat_total - beats_before == 6) else
            report_fail($sformatf("ERR %s beat count: expected 6, actual %0d",
                                  name, beat_total - beats_before));
    endtask

    //////////////////////////////
    // checker
    //////////////////////////////

    always @(posedge clk) begin
        logic [8:0] exp_val;
        int         beat_idx;
        if (rst_n) begin
            if (out_valid) begin
                assert (exp_q.size() != 0) else
                    report_fail($sformatf("out_valid high with no beat pending in %s",
                                          test_name));
                if (exp_q.size() != 0) begin
                    beat_idx = 6 - exp_q.size();
                    exp_val  = exp_q.pop_front();
                    assert (out_data == exp_val) else
                        report_fail($sformatf("ERR %s beat %0d: expected %0d, actual %0d",
                                              test_name, beat_idx, exp_val, out_data));
                    beat_total <= beat_total + 1;
                end
            end else begin
                // idle output must read as zero
                assert (out_data == '0) else
                    report_fail($sformatf("ERR %s idle output: expected 0, actual %0d",
                                          test_name, out_data));
            end
        end
    end

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        logic [53:0] frame;
        logic [8:0]  elem;
        logic [8:0]  bits;
        logic [2:0]  mode;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_data  = '0;
        in_mode  = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (10) @(posedge clk);

        frame = pack6(5, 100, 508, 0, 1, 300);
        run_frame("mode0_pass", frame, 3'd0, scale_by_four(frame));

        // inverse, edge values 0, 1 and p-1
        frame = pack6(0, 1, 508, 2, 254, 400);
        run_frame("inv_edges", frame, 3'd1, sp_ref(frame, 3'd1));
        frame = pack6(3, 508, 1, 0, 77, 123);
        run_frame("inv_mixed", frame, 3'd1, sp_ref(frame, 3'd1));

        frame = pack6(1, 2, 3, 4, 5, 6);
        run_frame("prod_small", frame, 3'd2, sp_ref(frame, 3'd2));
        frame = pack6(7, 0, 9, 11, 13, 500);
        run_frame("prod_zero", frame, 3'd2, sp_ref(frame, 3'd2));
        frame = pack6(5, 5, 5, 17, 17, 2);
        run_frame("prod_repeat", frame, 3'd2, sp_ref(frame, 3'd2));

        frame = pack6(9, 3, 9, 3, 508, 0);
        run_frame("sort_repeat", frame, 3'd4, sp_ref(frame, 3'd4));
        frame = pack6(508, 400, 300, 200, 100, 0);
        run_frame("sort_reverse", frame, 3'd4, sp_ref(frame, 3'd4));

        // random frames and modes, back to back
        for (int f = 0; f < 20; f++) begin
            for (int i = 0; i < 6; i++) begin
                draw_element(elem);
                frame[9*i +: 9] = elem;
            end
            draw_bits(3, bits);
            mode = bits[2:0];
            run_frame($sformatf("random_%0d_mode%0d", f, mode), frame, mode,
                      sp_ref(frame, mode));
        end

        repeat (4) @(posedge clk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- design/sp_top.sv
`timescale 1ns/1ps

module sp_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            in_valid,
    input  logic [sp_field_pkg::ELEM_W-1:0] in_data,
    input  logic [sp_ctrl_pkg::MODE_SORT:0] in_mode,
    output logic                            out_valid,
    output logic [sp_field_pkg::ELEM_W-1:0] out_data
);
    import sp_field_pkg::*;

    // start/done pulses between ctrl and the units
    logic inv_start;
    logic inv_done;
    logic prod_start;
    logic prod_done;
    logic sort_start;
    logic sort_done;

    // vectors between the stages
    logic [ELEM_W-1:0] in_vec   [N_ELEM];
    logic [ELEM_W-1:0] inv_vec  [N_ELEM];
    logic [ELEM_W-1:0] inv_sel  [N_ELEM];
    logic [ELEM_W-1:0] prod_vec [N_ELEM];
    logic [ELEM_W-1:0] prod_sel [N_ELEM];
    logic [ELEM_W-1:0] sort_vec [N_ELEM];

    sp_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_mode    (in_mode),
        .inv_done   (inv_done),
        .inv_vec    (inv_vec),
        .prod_done  (prod_done),
        .prod_vec   (prod_vec),
        .sort_done  (sort_done),
        .sort_vec   (sort_vec),
        .inv_start  (inv_start),
        .prod_start (prod_start),
        .sort_start (sort_start),
        .in_vec     (in_vec),
        .inv_sel    (inv_sel),
        .prod_sel   (prod_sel),
        .out_valid  (out_valid),
        .out_data   (out_data)
    );

    inv_unit u_inv (
        .clk       (clk),
        .rst_n     (rst_n),
        .inv_start (inv_start),
        .in_vec    (in_vec),
        .inv_done  (inv_done),
        .inv_vec   (inv_vec)
    );

    prod_unit u_prod (
        .clk        (clk),
        .rst_n      (rst_n),
        .prod_start (prod_start),
        .vec_in     (inv_sel),
        .prod_done  (prod_done),
        .prod_vec   (prod_vec)
    );

    sort_net u_sort (
        .clk        (clk),
        .rst_n      (rst_n),
        .sort_start (sort_start),
        .vec_in     (prod_sel),
        .sort_done  (sort_done),
        .sort_vec   (sort_vec)
    );

endmodule

//--- design/sp_ctrl.sv
`timescale 1ns/1ps

module sp_ctrl (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            in_valid,
    input  logic [sp_field_pkg::ELEM_W-1:0] in_data,
    input  logic [sp_ctrl_pkg::MODE_SORT:0] in_mode,
    input  logic                            inv_done,
    input  logic [sp_field_pkg::ELEM_W-1:0] inv_vec  [sp_field_pkg::N_ELEM],
    input  logic                            prod_done,
    input  logic [sp_field_pkg::ELEM_W-1:0] prod_vec [sp_field_pkg::N_ELEM],
    input  logic                            sort_done,
    input  logic [sp_field_pkg::ELEM_W-1:0] sort_vec [sp_field_pkg::N_ELEM],
    output logic                            inv_start,
    output logic                            prod_start,
    output logic                            sort_start,
    output logic [sp_field_pkg::ELEM_W-1:0] in_vec   [sp_field_pkg::N_ELEM],
    output logic [sp_field_pkg::ELEM_W-1:0] inv_sel  [sp_field_pkg::N_ELEM],
    output logic [sp_field_pkg::ELEM_W-1:0] prod_sel [sp_field_pkg::N_ELEM],
    output logic                            out_valid,
    output logic [sp_field_pkg::ELEM_W-1:0] out_data
);
    import sp_field_pkg::*;
    import sp_ctrl_pkg::*;

    state_e              state;
    state_e              nxt;
    logic                advance;
    logic [MODE_SORT:0]  mode_q;
    logic [IDX_W-1:0]    cnt;
    logic [ELEM_W-1:0]   sort_sel [N_ELEM];
    logic [ELEM_W+1:0]   sum_raw;
    logic [ELEM_W:0]     sum_fold;
    logic [ELEM_W:0]     sum_red;

    // first enabled stage after s, or output when none is left
    function automatic state_e next_after(input state_e s, input logic [MODE_SORT:0] m);
        if (s == ST_INPUT && m[MODE_INV])
            return ST_INV;
        if ((s == ST_INPUT || s == ST_INV) && m[MODE_PROD])
            return ST_PROD;
        if (s != ST_SORT && m[MODE_SORT])
            return ST_SORT;
        return ST_OUT;
    endfunction

    //////////////////////////////
    // sequencing
    //////////////////////////////

    always_comb begin
        advance = (state == ST_INPUT && cnt == IDX_W'(N_ELEM - 1))
               || (state == ST_INV  && inv_done)
               || (state == ST_PROD && prod_done)
               || (state == ST_SORT && sort_done);
        nxt = next_after(state, mode_q);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            mode_q     <= '0;
            cnt        <= '0;
            inv_start  <= 1'b0;
            prod_start <= 1'b0;
            sort_start <= 1'b0;
        end else begin
            inv_start  <= 1'b0;
            prod_start <= 1'b0;
            sort_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (in_valid) begin
                        state  <= ST_INPUT;
                        mode_q <= in_mode;
                        cnt    <= IDX_W'(1);
                    end
                end
                ST_INPUT: cnt <= cnt + 1'b1;
                ST_OUT: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == IDX_W'(N_ELEM - 1))
                        state <= ST_IDLE;
                end
                default: ;
            endcase
            if (advance) begin
                state      <= nxt;
                cnt        <= '0;
                inv_start  <= (nxt == ST_INV);
                prod_start <= (nxt == ST_PROD);
                sort_start <= (nxt == ST_SORT);
            end
        end
    end

    // frame buffer
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && in_valid)
            in_vec[0] <= in_data;
        else if (state == ST_INPUT)
            in_vec[cnt] <= in_data;
    end

    //////////////////////////////
    // stage selection and sum
    //////////////////////////////

    // a disabled stage forwards its input vector
    always_comb begin
        for (int i = 0; i < N_ELEM; i++) begin
            inv_sel[i]  = mode_q[MODE_INV]  ? inv_vec[i]  : in_vec[i];
            prod_sel[i] = mode_q[MODE_PROD] ? prod_vec[i] : inv_sel[i];
            sort_sel[i] = mode_q[MODE_SORT] ? sort_vec[i] : prod_sel[i];
        end
    end

    // four terms below 509 fit in 11 bits, one fold and one subtract
    always_comb begin
        sum_raw  = in_vec[cnt] + inv_sel[cnt] + prod_sel[cnt] + sort_sel[cnt];
        sum_fold = sum_raw[ELEM_W-1:0] + sum_raw[ELEM_W+1:ELEM_W] * FOLD_K;
        sum_red  = (sum_fold >= MODULUS) ? sum_fold - MODULUS : sum_fold;
    end

    assign out_valid = (state == ST_OUT);
    assign out_data  = out_valid ? sum_red[ELEM_W-1:0] : '0;

    // source must hold off while a frame is in flight
    a_in_valid_idle: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> (state == ST_IDLE || state == ST_INPUT));

    a_out_range: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> ({1'b0, out_data} < MODULUS));

endmodule

//--- sort/sort_net.sv
`timescale 1ns/1ps

module sort_net (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            sort_start,
    input  logic [sp_field_pkg::ELEM_W-1:0] vec_in   [sp_field_pkg::N_ELEM],
    output logic                            sort_done,
    output logic [sp_field_pkg::ELEM_W-1:0] sort_vec [sp_field_pkg::N_ELEM]
);
    import sp_field_pkg::*;

    logic [ELEM_W-1:0] l1_d [N_ELEM];
    logic [ELEM_W-1:0] l1_q [N_ELEM];
    logic [ELEM_W-1:0] l2_d [N_ELEM];
    logic              l1_vld;

    // returns {min, max}
    function automatic logic [2*ELEM_W-1:0] cmp_swap(input logic [ELEM_W-1:0] x,
                                                     input logic [ELEM_W-1:0] y);
        return (y < x) ? {y, x} : {x, y};
    endfunction

    // pairs, then global min to 0 and global max to 5
    always_comb begin
        l1_d = vec_in;
        {l1_d[0], l1_d[1]} = cmp_swap(l1_d[0], l1_d[1]);
        {l1_d[2], l1_d[3]} = cmp_swap(l1_d[2], l1_d[3]);
        {l1_d[4], l1_d[5]} = cmp_swap(l1_d[4], l1_d[5]);
        {l1_d[0], l1_d[2]} = cmp_swap(l1_d[0], l1_d[2]);
        {l1_d[1], l1_d[5]} = cmp_swap(l1_d[1], l1_d[5]);
        {l1_d[0], l1_d[4]} = cmp_swap(l1_d[0], l1_d[4]);
        {l1_d[3], l1_d[5]} = cmp_swap(l1_d[3], l1_d[5]);
    end

    // 4-input sorter on the middle wires
    always_comb begin
        l2_d = l1_q;
        {l2_d[1], l2_d[2]} = cmp_swap(l2_d[1], l2_d[2]);
        {l2_d[3], l2_d[4]} = cmp_swap(l2_d[3], l2_d[4]);
        {l2_d[1], l2_d[3]} = cmp_swap(l2_d[1], l2_d[3]);
        {l2_d[2], l2_d[4]} = cmp_swap(l2_d[2], l2_d[4]);
        {l2_d[2], l2_d[3]} = cmp_swap(l2_d[2], l2_d[3]);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            l1_vld    <= 1'b0;
            sort_done <= 1'b0;
        end else begin
            l1_vld    <= sort_start;
            sort_done <= l1_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (sort_start)
            l1_q <= l1_d;
        if (l1_vld)
            sort_vec <= l2_d;
    end

    a_sorted: assert property (@(posedge clk) disable iff (!rst_n)
        sort_done |-> (sort_vec[0] <= sort_vec[1]) && (sort_vec[1] <= sort_vec[2])
                   && (sort_vec[2] <= sort_vec[3]) && (sort_vec[3] <= sort_vec[4])
                   && (sort_vec[4] <= sort_vec[5]));

endmodule

//--- arith/prod_unit.sv
`timescale 1ns/1ps

module prod_unit (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            prod_start,
    input  logic [sp_field_pkg::ELEM_W-1:0] vec_in   [sp_field_pkg::N_ELEM],
    output logic                            prod_done,
    output logic [sp_field_pkg::ELEM_W-1:0] prod_vec [sp_field_pkg::N_ELEM]
);
    import sp_field_pkg::*;

    // operand and destination codes, bit 3 marks the scratch array
    logic [3:0]          step;
    logic [3:0]          src_a;
    logic [3:0]          src_b;
    logic [3:0]          dst;
    logic [3:0]          tag_q [3];
    logic [ELEM_W-1:0]   scratch [N_ELEM];
    logic [N_ELEM-1:0]   scr_vld;
    logic                ready;
    logic                issue;
    logic                mul_out_valid;
    logic [ELEM_W-1:0]   mul_a;
    logic [ELEM_W-1:0]   mul_b;
    logic [ELEM_W-1:0]   mul_p;

    // scratch: 0 a5a4, 1 a5a4a3, 2 a5..a2, 3 a0a1, 4 a0a1a2, 5 a0..a3
    always_comb begin
        case (step)
            4'd0:    {src_a, src_b, dst} = 12'h548;
            4'd1:    {src_a, src_b, dst} = 12'h839;
            4'd2:    {src_a, src_b, dst} = 12'h92A;
            4'd3:    {src_a, src_b, dst} = 12'h01B;
            4'd4:    {src_a, src_b, dst} = 12'hA10;
            4'd5:    {src_a, src_b, dst} = 12'hA01;
            4'd6:    {src_a, src_b, dst} = 12'hB92;
            4'd7:    {src_a, src_b, dst} = 12'hB2C;
            4'd8:    {src_a, src_b, dst} = 12'hC83;
            4'd9:    {src_a, src_b, dst} = 12'hC3D;
            4'd10:   {src_a, src_b, dst} = 12'hD54;
            4'd11:   {src_a, src_b, dst} = 12'hD45;
            default: {src_a, src_b, dst} = 12'h000;
        endcase
    end

    // in-order issue, stall until scratch operands are back
    assign ready = (!src_a[3] || scr_vld[src_a[2:0]])
                && (!src_b[3] || scr_vld[src_b[2:0]]);
    assign issue = (step != 4'd12) && ready;
    assign mul_a = src_a[3] ? scratch[src_a[2:0]] : vec_in[src_a[2:0]];
    assign mul_b = src_b[3] ? scratch[src_b[2:0]] : vec_in[src_b[2:0]];

    mod_mul u_mul (
        .clk           (clk),
        .rst_n         (rst_n),
        .mul_valid     (issue),
        .a             (mul_a),
        .b             (mul_b),
        .mul_out_valid (mul_out_valid),
        .p             (mul_p)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step      <= 4'd12;
            scr_vld   <= '0;
            prod_done <= 1'b0;
        end else begin
            // output 5 is the last result to leave the pipe
            prod_done <= mul_out_valid && (tag_q[2] == 4'd5);
            if (prod_start) begin
                step    <= '0;
                scr_vld <= '0;
            end else begin
                if (issue)
                    step <= step + 1'b1;
                if (mul_out_valid && tag_q[2][3])
                    scr_vld[tag_q[2][2:0]] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        tag_q[0] <= dst;
        tag_q[1] <= tag_q[0];
        tag_q[2] <= tag_q[1];
        if (mul_out_valid) begin
            if (tag_q[2][3])
                scratch[tag_q[2][2:0]] <= mul_p;
            else
                prod_vec[tag_q[2][2:0]] <= mul_p;
        end
    end

endmodule

//--- arith/inv_unit.sv
`timescale 1ns/1ps

module inv_unit (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            inv_start,
    input  logic [sp_field_pkg::ELEM_W-1:0] in_vec  [sp_field_pkg::N_ELEM],
    output logic                            inv_done,
    output logic [sp_field_pkg::ELEM_W-1:0] inv_vec [sp_field_pkg::N_ELEM]
);
    import sp_field_pkg::*;

    typedef enum logic [1:0] {
        INV_IDLE,
        INV_ISSUE,
        INV_WAIT
    } inv_state_e;

    inv_state_e          state;
    logic                op_mul;
    logic [3:0]          bit_idx;
    logic [IDX_W-1:0]    elem_idx;
    logic [ELEM_W-1:0]   acc;
    logic                take_mul;
    logic                last_bit;
    logic                last_elem;
    logic                elem_end;
    logic                mul_valid;
    logic                mul_out_valid;
    logic [ELEM_W-1:0]   mul_b;
    logic [ELEM_W-1:0]   mul_p;

    // square on acc, or multiply acc by the base element
    assign mul_valid = (state == INV_ISSUE);
    assign mul_b     = op_mul ? in_vec[elem_idx] : acc;

    assign take_mul  = !op_mul && INV_EXP[bit_idx];
    assign last_bit  = (bit_idx == '0);
    assign last_elem = (elem_idx == IDX_W'(N_ELEM - 1));
    assign elem_end  = mul_out_valid && !take_mul && last_bit;

    mod_mul u_mul (
        .clk           (clk),
        .rst_n         (rst_n),
        .mul_valid     (mul_valid),
        .a             (acc),
        .b             (mul_b),
        .mul_out_valid (mul_out_valid),
        .p             (mul_p)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= INV_IDLE;
            op_mul   <= 1'b0;
            bit_idx  <= '0;
            elem_idx <= '0;
            inv_done <= 1'b0;
        end else begin
            inv_done <= 1'b0;
            case (state)
                INV_IDLE: begin
                    if (inv_start) begin
                        state    <= INV_ISSUE;
                        op_mul   <= 1'b0;
                        bit_idx  <= 4'(EXP_W - 1);
                        elem_idx <= '0;
                    end
                end
                INV_ISSUE: state <= INV_WAIT;
                INV_WAIT: begin
                    if (mul_out_valid) begin
                        if (take_mul) begin
                            op_mul <= 1'b1;
                            state  <= INV_ISSUE;
                        end else begin
                            op_mul  <= 1'b0;
                            bit_idx <= last_bit ? 4'(EXP_W - 1) : bit_idx - 1'b1;
                            if (last_bit && last_elem) begin
                                state    <= INV_IDLE;
                                inv_done <= 1'b1;
                            end else begin
                                state <= INV_ISSUE;
                                if (last_bit)
                                    elem_idx <= elem_idx + 1'b1;
                            end
                        end
                    end
                end
                default: state <= INV_IDLE;
            endcase
        end
    end

    // running power, restarted at 1 for every element
    always_ff @(posedge clk) begin
        if (state == INV_IDLE && inv_start)
            acc <= ELEM_W'(1);
        else if (mul_out_valid)
            acc <= elem_end ? ELEM_W'(1) : mul_p;
        if (elem_end)
            inv_vec[elem_idx] <= mul_p;
    end

endmodule

//--- arith/mod_mul.sv
`timescale 1ns/1ps

module mod_mul (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            mul_valid,
    input  logic [sp_field_pkg::ELEM_W-1:0] a,
    input  logic [sp_field_pkg::ELEM_W-1:0] b,
    output logic                            mul_out_valid,
    output logic [sp_field_pkg::ELEM_W-1:0] p
);
    import sp_field_pkg::*;

    logic [PROD_W-1:0]   prod_q;
    logic [ELEM_W+1:0]   fold_q;
    logic [ELEM_W:0]     fold2;
    logic [ELEM_W:0]     p_red;
    logic [1:0]          vld_q;

    // second fold leaves at most 520, so one subtract is enough
    always_comb begin
        fold2 = fold_q[ELEM_W-1:0] + fold_q[ELEM_W+1:ELEM_W] * FOLD_K;
        p_red = (fold2 >= MODULUS) ? fold2 - MODULUS : fold2;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q         <= '0;
            mul_out_valid <= 1'b0;
        end else begin
            vld_q         <= {vld_q[0], mul_valid};
            mul_out_valid <= vld_q[1];
        end
    end

    always_ff @(posedge clk) begin
        prod_q <= a * b;
        // upper 9 bits carry weight 512 = 3 mod p
        fold_q <= prod_q[ELEM_W-1:0] + prod_q[PROD_W-1:ELEM_W] * FOLD_K;
        p      <= p_red[ELEM_W-1:0];
    end

    a_p_range: assert property (@(posedge clk) disable iff (!rst_n)
        mul_out_valid |-> ({1'b0, p} < MODULUS));

endmodule

//--- common/sp_ctrl_pkg.sv
package sp_ctrl_pkg;

    // top level sequencing states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_INPUT,
        ST_INV,
        ST_PROD,
        ST_SORT,
        ST_OUT
    } state_e;

    // bit positions inside in_mode
    typedef enum logic [1:0] {
        MODE_INV  = 2'd0,
        MODE_PROD = 2'd1,
        MODE_SORT = 2'd2
    } mode_bit_e;

endpackage

//--- common/sp_field_pkg.sv
package sp_field_pkg;

    //////////////////////////////
    // field constants
    //////////////////////////////

    // the field prime
    localparam logic [9:0] MODULUS = 10'd509;

    // element and frame sizing
    localparam int ELEM_W = 9;
    localparam int N_ELEM = 6;
    localparam int IDX_W  = 3;

    // full width of an element product
    localparam int PROD_W = 2 * ELEM_W;

    // 2^9 = 509 + 3, so upper bits fold back with weight 3
    localparam logic [1:0] FOLD_K = 2'd3;

    //////////////////////////////
    // inversion exponent
    //////////////////////////////

    // p - 2 for fermat inversion
    localparam logic [8:0] INV_EXP = 9'd507;
    localparam int         EXP_W   = 9;

endpackage
